//--- Bender.yml
package:
  name: eeprom_wr

export_include_dirs:
  - rtl

sources:
  - rtl/eeprom_pkg.sv
  - rtl/eeprom_req_stage.sv
  - rtl/eeprom_bit_seq.sv
  - rtl/eeprom_line_drv.sv
  - rtl/eeprom_wr.sv
  - target: simulation
    files:
      - sim/eeprom_model.sv
      - sim/eeprom_wr_properties.sv
      - sim/eeprom_wr_tb.sv

//--- rtl/eeprom_bit_seq.sv
`timescale 1ns/1ns
`default_nettype none

`include "eeprom_config.svh"

module eeprom_bit_seq (
    input  logic                      CLK,
    input  logic                      RESET,
    input  eeprom_pkg::eeprom_frame_t frame,
    input  logic                      start,
    output logic                      busy,
    output eeprom_pkg::line_cmd_t     cmd
);

    import eeprom_pkg::*;

    localparam int PH_W = $clog2(`EEPROM_PHASES);
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(`EEPROM_PHASES - 1);
    localparam logic [PH_W-1:0] PH_HIGH = PH_W'(`EEPROM_PHASES / 2);

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_WR_START,
        S_CTRL_WR,
        S_ADDR_WR,
        S_DATA_WR,
        S_RD_START,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP
    } state_e;

    state_e          state;
    state_e          state_nxt;
    logic [PH_W-1:0] phase;
    logic [2:0]      bit_cnt;     // bit within the current byte, MSB first
    logic            slot_end;
    logic            scl_lvl;
    logic [7:0]      tx_byte;

    assign busy     = (state != S_IDLE);
    assign slot_end = (phase == PH_LAST);
    assign scl_lvl  = (phase >= PH_HIGH);

    // next field, taken at the end of a bit slot
    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
                if (start)
                    state_nxt = S_WR_START;
            S_WR_START:
                state_nxt = S_CTRL_WR;
            S_CTRL_WR:
                if (bit_cnt == 3'd0)
                    state_nxt = S_ADDR_WR;
            S_ADDR_WR:
                if (bit_cnt == 3'd0)
                    state_nxt = (frame.op == OP_READ) ? S_RD_START : S_DATA_WR;
            S_DATA_WR:
                if (bit_cnt == 3'd0)
                    state_nxt = S_STOP;
            S_RD_START:
                state_nxt = S_CTRL_RD;      // repeated start
            S_CTRL_RD:
                if (bit_cnt == 3'd0)
                    state_nxt = S_DATA_RD;
            S_DATA_RD:
                if (bit_cnt == 3'd0)
                    state_nxt = S_STOP;
            S_STOP:
                state_nxt = S_IDLE;
            default:
                state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            phase   <= '0;
            bit_cnt <= 3'd7;
        end
        else if (state == S_IDLE)
        begin
            phase   <= '0;
            bit_cnt <= 3'd7;
            state   <= state_nxt;
        end
        else
        begin
            phase <= slot_end ? '0 : phase + 1'b1;
            if (slot_end)
            begin
                state <= state_nxt;
                // reload on every field change, count down inside a byte
                if (state_nxt != state)
                    bit_cnt <= 3'd7;
                else
                    bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // byte on the wire for the current field
    always_comb
    begin
        case (state)
            S_CTRL_WR: tx_byte = {`EEPROM_DEV_CODE, frame.addr[`EEPROM_ADDR_W-1:8], 1'b0};
            S_CTRL_RD: tx_byte = {`EEPROM_DEV_CODE, frame.addr[`EEPROM_ADDR_W-1:8], 1'b1};
            S_ADDR_WR: tx_byte = frame.addr[7:0];
            default:   tx_byte = frame.data;
        endcase
    end

    always_comb
    begin
        // idle: SCL high, SDA released
        cmd = '{scl: 1'b1, sda_oe: 1'b0, sda_val: 1'b1, sample: 1'b0, last: 1'b0, done: 1'b0};
        case (state)
            S_WR_START, S_RD_START:
            begin
                cmd.scl     = scl_lvl;
                cmd.sda_oe  = 1'b1;
                cmd.sda_val = !slot_end;    // falls mid SCL high
            end
            S_CTRL_WR, S_ADDR_WR, S_DATA_WR, S_CTRL_RD:
            begin
                cmd.scl     = scl_lvl;
                cmd.sda_oe  = 1'b1;
                cmd.sda_val = tx_byte[bit_cnt];
            end
            S_DATA_RD:
            begin
                cmd.scl    = scl_lvl;
                cmd.sample = (phase == PH_HIGH);
                cmd.last   = (phase == PH_HIGH) && (bit_cnt == 3'd0);
            end
            S_STOP:
            begin
                cmd.scl     = scl_lvl;
                cmd.sda_oe  = 1'b1;
                cmd.sda_val = slot_end;     // rises mid SCL high
                cmd.done    = slot_end;
            end
            default:
            begin
                cmd.scl = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// byte address, 24C16 style part
`define EEPROM_ADDR_W 11

// top nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// CLK cycles per bus bit, SCL low for the first half
`define EEPROM_PHASES 4

`endif

//--- rtl/eeprom_line_drv.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_line_drv (
    input  logic                  CLK,
    input  logic                  RESET,
    input  eeprom_pkg::line_cmd_t cmd,
    output logic                  SCL,
    inout  wire                   SDA,
    output logic [7:0]            rd_data,
    output logic                  ACK
);

    logic       sda_oe;
    logic       sda_out;
    logic       sample_q;
    logic       last_q;
    logic       rd_ready;   // byte complete, waiting for done
    logic [7:0] shift;

    assign SDA = sda_oe ? sda_out : 1'bz;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            SCL      <= 1'b1;
            sda_oe   <= 1'b0;
            sda_out  <= 1'b1;
            sample_q <= 1'b0;
            last_q   <= 1'b0;
            ACK      <= 1'b0;
        end
        else
        begin
            SCL      <= cmd.scl;
            sda_oe   <= cmd.sda_oe;
            sda_out  <= cmd.sda_val;
            sample_q <= cmd.sample;
            last_q   <= cmd.last;
            ACK      <= cmd.done;
        end
    end

    // sampled after one cycle of SCL high
    always_ff @(posedge CLK)
    begin
        if (sample_q)
            shift <= {shift[6:0], SDA};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            rd_ready <= 1'b0;
        else if (sample_q && last_q)
            rd_ready <= 1'b1;
        else if (cmd.done)
            rd_ready <= 1'b0;
    end

    // rd_data moves in the same edge as ACK
    always_ff @(posedge CLK)
    begin
        if (cmd.done && rd_ready)
            rd_data <= shift;
    end

endmodule

`default_nettype wire

//--- rtl/eeprom_pkg.sv
`default_nettype none

`include "eeprom_config.svh"

package eeprom_pkg;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    // one request, held for the whole transaction
    typedef struct packed {
        eeprom_op_e                op;
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [7:0]                data;
    } eeprom_frame_t;

    // per-phase instruction to the line driver
    typedef struct packed {
        logic scl;      // SCL level
        logic sda_oe;   // drive SDA, else released
        logic sda_val;
        logic sample;   // shift SDA in
        logic last;     // eighth read bit
        logic done;     // end of transaction
    } line_cmd_t;

endpackage

`default_nettype wire

//--- rtl/eeprom_req_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "eeprom_config.svh"

module eeprom_req_stage (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      WR,
    input  logic                      RD,
    input  logic [`EEPROM_ADDR_W-1:0] ADDR,
    input  logic [7:0]                wr_data,
    input  logic                      busy,
    output eeprom_pkg::eeprom_frame_t frame,
    output logic                      start
);

    import eeprom_pkg::*;

    logic take;

    // busy rises one cycle after start, so the start cycle blocks too
    assign take = (WR || RD) && !busy && !start;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start <= 1'b0;
        end
        else
        begin
            start <= take;
        end
    end

    // frame is held until the next accepted request
    always_ff @(posedge CLK)
    begin
        if (take)
        begin
            frame.op   <= WR ? OP_WRITE : OP_READ;  // write wins if both
            frame.addr <= ADDR;
            frame.data <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/eeprom_wr.sv
`timescale 1ns/1ns
`default_nettype none

`include "eeprom_config.svh"

module eeprom_wr (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      WR,
    input  logic                      RD,
    input  logic [`EEPROM_ADDR_W-1:0] ADDR,
    input  logic [7:0]                wr_data,
    output logic                      SCL,
    inout  wire                       SDA,
    output logic [7:0]                rd_data,
    output logic                      ACK
);

    import eeprom_pkg::*;

    eeprom_frame_t frame;
    logic          start;
    logic          busy;
    line_cmd_t     cmd;

    eeprom_req_stage u_req (
        .CLK     (CLK),
        .RESET   (RESET),
        .WR      (WR),
        .RD      (RD),
        .ADDR    (ADDR),
        .wr_data (wr_data),
        .busy    (busy),
        .frame   (frame),
        .start   (start)
    );

    // one command per CLK, registered by the line driver
    eeprom_bit_seq u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .frame (frame),
        .start (start),
        .busy  (busy),
        .cmd   (cmd)
    );

    eeprom_line_drv u_drv (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (cmd),
        .SCL     (SCL),
        .SDA     (SDA),
        .rd_data (rd_data),
        .ACK     (ACK)
    );

endmodule

`default_nettype wire

//--- sim/eeprom_cases.txt
# op addr data, all hex
# op 0 write data, 1 read expecting data, 2 read while a write of data is dropped
1 000 ff
0 000 5a
1 000 5a
0 0a5 3c
0 1a5 c3
0 2a5 96
0 7a5 69
1 0a5 3c
1 1a5 c3
1 2a5 96
1 7a5 69
1 3a5 ff
1 7ff ff
0 7ff 01
2 123 ee
1 123 ff
1 7ff 01

//--- sim/eeprom_model.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_model #(
    parameter int MEM_BYTES = 2048
) (
    input wire CLK,
    input wire SCL,
    inout wire SDA
);

    localparam logic [3:0] DEV_CODE = 4'b1010;

    logic [7:0] mem [0:MEM_BYTES-1];
    logic       scl_q;
    logic       sda_q;
    logic       active;     // between start and stop
    logic       sending;    // read data phase, slave owns SDA
    logic       pull_low;
    logic [7:0] rx;
    logic [2:0] rx_cnt;
    logic [1:0] byte_idx;
    logic [2:0] page;
    logic [7:0] low_addr;
    logic [7:0] tx;
    logic [3:0] tx_cnt;

    // open drain, the pullup gives the ones
    assign SDA = pull_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < MEM_BYTES; i++)
            mem[i] = 8'hff;
        scl_q    = 1'b1;
        sda_q    = 1'b1;
        active   = 1'b0;
        sending  = 1'b0;
        pull_low = 1'b0;
        rx_cnt   = 3'd0;
        byte_idx = 2'd0;
        page     = 3'd0;
        low_addr = 8'h00;
    end

    // bus oversampled on CLK, edges seen as changes between two samples
    always @(posedge CLK)
    begin : decode
        logic [7:0] rx_byte;
        rx_byte = {rx[6:0], SDA};
        scl_q <= SCL;
        sda_q <= SDA;
        if (scl_q && SCL && sda_q && !SDA)
        begin
            active   <= 1'b1;   // start or repeated start
            sending  <= 1'b0;
            pull_low <= 1'b0;
            rx_cnt   <= 3'd0;
            byte_idx <= 2'd0;
        end
        else if (scl_q && SCL && !sda_q && SDA)
        begin
            active   <= 1'b0;   // stop
            sending  <= 1'b0;
            pull_low <= 1'b0;
        end
        else if (active && !sending && !scl_q && SCL)
        begin
            rx     <= rx_byte;
            rx_cnt <= rx_cnt + 3'd1;
            if (rx_cnt == 3'd7)
            begin
                byte_idx <= byte_idx + 2'd1;
                case (byte_idx)
                    2'd0:
                    begin
                        page <= rx_byte[3:1];
                        if (rx_byte[7:4] != DEV_CODE)
                            active <= 1'b0;     // not addressed
                        else if (rx_byte[0])
                        begin
                            sending <= 1'b1;
                            tx      <= mem[{rx_byte[3:1], low_addr}];
                            tx_cnt  <= 4'd0;
                        end
                    end
                    2'd1:
                        low_addr <= rx_byte;
                    2'd2:
                        mem[{page, low_addr}] <= rx_byte;
                    default:
                        rx <= rx_byte;
                endcase
            end
        end
        else if (active && sending && scl_q && !SCL)
        begin
            if (tx_cnt == 4'd8)
            begin
                pull_low <= 1'b0;   // all eight out, hand SDA back
                sending  <= 1'b0;
            end
            else
            begin
                pull_low <= !tx[7];
                tx       <= {tx[6:0], 1'b0};
                tx_cnt   <= tx_cnt + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/eeprom_wr_properties.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_wr_properties (
    input logic CLK,
    input logic RESET,
    input logic SCL,
    input logic SDA,
    input logic ACK,
    input logic busy
);

    // bus bit number of each framing slot, counted from 1
    localparam logic [5:0] START_BIT   = 6'd1;
    localparam logic [5:0] RESTART_BIT = 6'd18;
    localparam logic [5:0] WR_STOP_BIT = 6'd26;
    localparam logic [5:0] RD_STOP_BIT = 6'd35;

    logic       scl_q;
    logic [5:0] slot;   // SCL rises since busy went high

    always_ff @(posedge CLK)
    begin
        if (RESET)
            scl_q <= 1'b1;
        else
            scl_q <= SCL;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET || !busy)
            slot <= '0;
        else if (SCL && !scl_q)
            slot <= slot + 6'd1;
    end

    // data never moves under SCL high, start and stop move it mid high
    sda_framing: assert property (@(posedge CLK) disable iff (RESET)
        (SCL && $past(SCL) && $changed(SDA)) |-> !$past(SCL, 2) &&
            (SDA ? (slot == WR_STOP_BIT || slot == RD_STOP_BIT)
                 : (slot == START_BIT || slot == RESTART_BIT)))
        else $error("SDA changed while SCL high outside start or stop");

    ack_single: assert property (@(posedge CLK) disable iff (RESET)
        ACK |=> !ACK)
        else $error("ACK high for two cycles");

    scl_toggle: assert property (@(posedge CLK) disable iff (RESET)
        (busy && $past(busy) && $past(busy, 2) && $past(busy, 3)) |-> (SCL != $past(SCL, 2)))
        else $error("SCL did not toggle after two cycles while busy");

endmodule

bind eeprom_wr eeprom_wr_properties u_props (
    .CLK   (CLK),
    .RESET (RESET),
    .SCL   (SCL),
    .SDA   (SDA),
    .ACK   (ACK),
    .busy  (busy)
);

`default_nettype wire

//--- sim/eeprom_wr_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "eeprom_config.svh"

module eeprom_wr_tb;

    localparam int          HALF_PERIOD = 20;
    localparam int          ACK_TIMEOUT = 400;
    localparam int          MEM_BYTES   = 2048;
    localparam logic [31:0] LFSR_SEED   = 32'habff;

    logic                      CLK;
    logic                      RESET;
    logic                      WR;
    logic                      RD;
    logic [`EEPROM_ADDR_W-1:0] ADDR;
    logic [7:0]                wr_data;
    logic                      SCL;
    wire                       SDA;
    logic [7:0]                rd_data;
    logic                      ACK;

    logic [7:0]  ref_mem [0:MEM_BYTES-1];
    logic [31:0] lfsr;
    int          ack_total;
    int          n_pass;
    int          n_fail;

    pullup (SDA);

    eeprom_wr uut (
        .CLK     (CLK),
        .RESET   (RESET),
        .WR      (WR),
        .RD      (RD),
        .ADDR    (ADDR),
        .wr_data (wr_data),
        .SCL     (SCL),
        .SDA     (SDA),
        .rd_data (rd_data),
        .ACK     (ACK)
    );

    eeprom_model #(.MEM_BYTES(MEM_BYTES)) slave (
        .CLK (CLK),
        .SCL (SCL),
        .SDA (SDA)
    );

    always #HALF_PERIOD CLK = !CLK;

    always @(negedge CLK)
    begin
        if (ACK === 1'b1)
            ack_total++;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic send_request(input logic is_read, input logic [`EEPROM_ADDR_W-1:0] a,
                                input logic [7:0] d);
        @(posedge CLK);
        WR      <= !is_read;
        RD      <= is_read;
        ADDR    <= a;
        wr_data <= d;
        @(posedge CLK);
        WR <= 1'b0;
        RD <= 1'b0;
    endtask

    task automatic wait_for_ack(output logic got);
        int n;
        got = 1'b0;
        n   = 0;
        while (!got && n < ACK_TIMEOUT)
        begin
            @(negedge CLK);
            n++;
            if (ACK === 1'b1)
                got = 1'b1;
        end
    endtask

    // op 0 write, 1 read expecting d, 2 read with a write dropped while busy
    task automatic run_case(input int num, input logic [3:0] op,
                            input logic [`EEPROM_ADDR_W-1:0] a, input logic [7:0] d);
        int         acks_before;
        logic       got;
        logic       ok;
        logic [7:0] expected;
        ok          = 1'b1;
        acks_before = ack_total;
        expected    = (op == 4'h1) ? d : ref_mem[a];
        send_request(op != 4'h0, a, d);
        if (op == 4'h2)
        begin
            repeat (8) @(posedge CLK);
            send_request(1'b0, a, d);
        end
        wait_for_ack(got);
        assert (got)
        else
        begin
            $display("case %0d: no ACK within %0d cycles", num, ACK_TIMEOUT);
            ok = 1'b0;
        end
        if (got && op != 4'h0)
        begin
            assert (rd_data === expected)
            else
            begin
                $display("** Error: rd_data = %h, expected %h", rd_data, expected);
                ok = 1'b0;
            end
        end
        @(negedge CLK);
        assert (ACK === 1'b0)
        else
        begin
            $display("case %0d: ACK stayed high for more than one cycle", num);
            ok = 1'b0;
        end
        if (op == 4'h2)
            repeat (150) @(posedge CLK);    // room for a stray ACK
        @(posedge CLK);
        assert (ack_total - acks_before == 1)
        else
        begin
            $display("** Error: ACK pulses = %h, expected 01", 8'(ack_total - acks_before));
            ok = 1'b0;
        end
        if (op == 4'h0)
            ref_mem[a] = d;
        if (op != 4'h1)
        begin
            assert (slave.mem[a] === ref_mem[a])
            else
            begin
                $display("** Error: model mem[%h] = %h, expected %h", a, slave.mem[a], ref_mem[a]);
                ok = 1'b0;
            end
        end
        $display("case %0d op %0h addr %h data %h: %s", num, op, a, d, ok ? "ok" : "FAIL");
        if (ok)
            n_pass++;
        else
            n_fail++;
    endtask

    initial
    begin
        int          fd;
        int          num;
        logic        ok;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] r_addr;
        logic [31:0] r_data;
        CLK       = 1'b0;
        RESET     = 1'b1;
        WR        = 1'b0;
        RD        = 1'b0;
        ADDR      = '0;
        wr_data   = 8'h00;
        lfsr      = LFSR_SEED;
        ack_total = 0;
        n_pass    = 0;
        n_fail    = 0;
        num       = 0;
        for (int i = 0; i < MEM_BYTES; i++)
            ref_mem[i] = 8'hff;
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        ok = 1'b1;
        assert (SCL === 1'b1 && SDA === 1'b1 && ACK === 1'b0)
        else
        begin
            $display("** Error: SCL = %h, SDA = %h, ACK = %h, expected 1 1 0", SCL, SDA, ACK);
            ok = 1'b0;
        end
        $display("reset: %s", ok ? "ok" : "FAIL");
        if (ok)
            n_pass++;
        else
            n_fail++;
        fd = $fopen("sim/eeprom_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open sim/eeprom_cases.txt");
            n_fail++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if ($sscanf(line, "%h %h %h", f_op, f_addr, f_data) == 3)
                begin
                    num++;
                    run_case(num, f_op[3:0], f_addr[`EEPROM_ADDR_W-1:0], f_data[7:0]);
                end
            end
            $fclose(fd);
        end
        // random write then read back pairs
        for (int k = 0; k < 16; k++)
        begin
            take_bits(`EEPROM_ADDR_W, r_addr);
            take_bits(8, r_data);
            num++;
            run_case(num, 4'h0, r_addr[`EEPROM_ADDR_W-1:0], r_data[7:0]);
            num++;
            run_case(num, 4'h1, r_addr[`EEPROM_ADDR_W-1:0], ref_mem[r_addr[`EEPROM_ADDR_W-1:0]]);
        end
        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/eeprom_pkg.sv
rtl/eeprom_req_stage.sv
rtl/eeprom_bit_seq.sv
rtl/eeprom_line_drv.sv
rtl/eeprom_wr.sv
sim/eeprom_model.sv
sim/eeprom_wr_properties.sv
sim/eeprom_wr_tb.sv
